// ==== rtl/memPkg.sv ====
package memPkg;

    // byte-addressed memory bus
    typedef logic [31:0] memAddr;
    typedef logic [7:0]  memByte;
    typedef logic [31:0] memWord;

    // byte count of one access, only 1, 2 and 4 are legal
    typedef logic [2:0] accessLen;

    localparam accessLen wordLen = 3'd4;

    typedef struct packed {
        logic     isStore;
        accessLen len;
        memAddr   addr;
        memWord   wdata;
    } dataReq;

    typedef struct packed {
        logic   en;
        memAddr addr;
        memByte data;
    } ramWrite;

    // bytes gathered at the top of the word, low byte first
    function automatic memWord alignLoad(memWord gathered, accessLen len);
        return gathered >> {wordLen - len, 3'b000};
    endfunction

    // byte idx of a store word, little endian
    function automatic memByte storeByte(memWord wdata, accessLen idx);
        return memByte'(wdata >> {idx, 3'b000});
    endfunction

endpackage

// ==== rtl/cpuPkg.sv ====
package cpuPkg;

    // who holds the memory controller for the current transaction
    typedef enum logic [1:0] {
        busIdle,
        busData,
        busFetch
    } busOwner;

    typedef struct packed {
        memPkg::memWord inst;
        memPkg::memAddr pc;
    } fetchOut;

    localparam memPkg::memAddr pcStep = 32'd4;

    function automatic memPkg::memAddr nextPc(memPkg::memAddr pc);
        return pc + pcStep;
    endfunction

endpackage

// ==== rtl/byteRam.sv ====
`timescale 1ns/1ps

module byteRam #(
    parameter int ramAddrBits = 12
) (
    input  logic            clk,
    input  memPkg::memAddr  ramAddr,
    input  memPkg::ramWrite ramWr,
    output memPkg::memByte  rdByte
);
    import memPkg::*;

    localparam int depth = 1 << ramAddrBits;

    memByte mem [depth];

    // ram powers up cleared
    initial begin
        for (int i = 0; i < depth; i++) begin
            mem[i] = '0;
        end
    end

    // upper address bits wrap onto the array
    always_ff @(posedge clk) begin
        if (ramWr.en) begin
            mem[ramWr.addr[ramAddrBits-1:0]] <= ramWr.data;
        end
        rdByte <= mem[ramAddr[ramAddrBits-1:0]];
    end

endmodule

// ==== rtl/memCtrl.sv ====
`timescale 1ns/1ps

module memCtrl (
    input  logic            clk,
    input  logic            rst,
    input  logic            ioBufferFull,
    input  logic            dataEn,
    input  memPkg::dataReq  dataRequest,
    input  logic            fetchReq,
    input  memPkg::memAddr  fetchAddr,
    input  memPkg::memByte  rdByte,
    output memPkg::memAddr  ramAddr,
    output memPkg::ramWrite ramWr,
    output logic            dataDone,
    output memPkg::memWord  dataRdata,
    output logic            fetchDone,
    output memPkg::memWord  fetchWord,
    output cpuPkg::busOwner owner
);
    import memPkg::*;
    import cpuPkg::*;

    // latched transaction
    busOwner  ownerQ;
    accessLen stage;
    dataReq   reqQ;
    memAddr   fetchAddrQ;
    memWord   gatherQ;

    // view of the transaction in the current cycle
    busOwner  curOwner;
    dataReq   curReq;
    memAddr   curFetchAddr;
    memAddr   baseAddr;
    accessLen lastStage;
    accessLen beat;
    logic     idle;
    logic     finish;

    assign idle = (ownerQ == busIdle);

    // when idle the incoming request is served as beat 0 right away
    // data wins a tie
    always_comb begin
        if (idle) begin
            curReq = dataRequest;
            curFetchAddr = fetchAddr;
            if (dataEn) begin
                curOwner = busData;
            end else if (fetchReq) begin
                curOwner = busFetch;
            end else begin
                curOwner = busIdle;
            end
        end else begin
            curReq = reqQ;
            curFetchAddr = fetchAddrQ;
            curOwner = ownerQ;
        end
    end

    // store ends on its last write, load one beat after its last byte arrives
    always_comb begin
        case (curOwner)
            busData: begin
                if (curReq.isStore) begin
                    lastStage = accessLen'(curReq.len - 3'd1);
                end else begin
                    lastStage = accessLen'(curReq.len + 3'd1);
                end
            end
            busFetch: lastStage = wordLen;
            default:  lastStage = '0;
        endcase
    end

    assign finish = (curOwner != busIdle) && !ioBufferFull && (stage == lastStage);

    // step back one beat while frozen so the byte due at resume is read again
    assign beat = (ioBufferFull && stage != '0) ? accessLen'(stage - 3'd1) : stage;

    assign baseAddr = (curOwner == busData) ? curReq.addr : curFetchAddr;
    assign ramAddr = baseAddr + memAddr'(beat);

    always_comb begin
        ramWr.en = !ioBufferFull && (curOwner == busData) && curReq.isStore
            && (stage < curReq.len);
        ramWr.addr = ramAddr;
        ramWr.data = storeByte(curReq.wdata, stage);
    end

    assign dataDone = finish && (curOwner == busData);
    assign fetchDone = finish && (curOwner == busFetch);

    assign dataRdata = alignLoad(gatherQ, reqQ.len);

    // last fetch byte goes straight from the ram
    assign fetchWord = {rdByte, gatherQ[31:8]};

    assign owner = ownerQ;

    always_ff @(posedge clk) begin
        if (rst) begin
            ownerQ <= busIdle;
            stage <= '0;
        end else if (!ioBufferFull) begin
            if (finish) begin
                ownerQ <= busIdle;
                stage <= '0;
            end else if (curOwner != busIdle) begin
                ownerQ <= curOwner;
                stage <= accessLen'(stage + 3'd1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!ioBufferFull && idle) begin
            reqQ <= dataRequest;
            fetchAddrQ <= fetchAddr;
        end
        // byte addressed in the previous beat arrives now
        if (!ioBufferFull && stage != '0) begin
            gatherQ <= {rdByte, gatherQ[31:8]};
        end
    end

endmodule

// ==== rtl/fetchUnit.sv ====
`timescale 1ns/1ps

module fetchUnit #(
    parameter memPkg::memAddr resetPc = '0
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            ioBufferFull,
    input  logic            fetchEn,
    input  logic            redirect,
    input  memPkg::memAddr  redirectPc,
    output logic            fetchReq,
    output memPkg::memAddr  fetchAddr,
    input  logic            fetchDone,
    input  memPkg::memWord  fetchWord,
    output logic            instValid,
    output cpuPkg::fetchOut instOut
);
    import memPkg::*;
    import cpuPkg::*;

    memAddr pc;
    memAddr flightPc;
    logic   pending;
    logic   stale;
    logic   start;

    // a raised request is held with its address until the done pulse
    assign start = !pending && fetchEn && !ioBufferFull;
    assign fetchReq = pending || start;
    assign fetchAddr = pending ? flightPc : pc;

    // words of a redirected fetch are dropped
    assign instValid = fetchDone && !stale && !redirect;
    assign instOut = '{inst: fetchWord, pc: flightPc};

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= resetPc;
            pending <= 1'b0;
            stale <= 1'b0;
        end else begin
            pending <= fetchReq && !fetchDone;
            if (redirect) begin
                pc <= redirectPc;
            end else if (instValid) begin
                pc <= nextPc(pc);
            end
            if (fetchDone) begin
                stale <= 1'b0;
            end else if (redirect && fetchReq) begin
                stale <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            flightPc <= pc;
        end
    end

endmodule

// ==== rtl/memSubsystem.sv ====
`timescale 1ns/1ps

module memSubsystem #(
    parameter int             ramAddrBits = 12,
    parameter memPkg::memAddr resetPc     = '0
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            ioBufferFull,
    input  logic            dataEn,
    input  memPkg::dataReq  dataRequest,
    output logic            dataDone,
    output memPkg::memWord  dataRdata,
    input  logic            fetchEn,
    input  logic            redirect,
    input  memPkg::memAddr  redirectPc,
    output logic            instValid,
    output cpuPkg::fetchOut instOut,
    output cpuPkg::busOwner owner
);
    import memPkg::*;

    logic    fetchReq;
    memAddr  fetchAddr;
    logic    fetchDone;
    memWord  fetchWord;
    memAddr  ramAddr;
    ramWrite ramWr;
    memByte  rdByte;

    fetchUnit #(
        .resetPc(resetPc)
    ) u_fetchUnit (
        .clk         (clk),
        .rst         (rst),
        .ioBufferFull(ioBufferFull),
        .fetchEn     (fetchEn),
        .redirect    (redirect),
        .redirectPc  (redirectPc),
        .fetchReq    (fetchReq),
        .fetchAddr   (fetchAddr),
        .fetchDone   (fetchDone),
        .fetchWord   (fetchWord),
        .instValid   (instValid),
        .instOut     (instOut)
    );

    memCtrl u_memCtrl (
        .clk         (clk),
        .rst         (rst),
        .ioBufferFull(ioBufferFull),
        .dataEn      (dataEn),
        .dataRequest (dataRequest),
        .fetchReq    (fetchReq),
        .fetchAddr   (fetchAddr),
        .rdByte      (rdByte),
        .ramAddr     (ramAddr),
        .ramWr       (ramWr),
        .dataDone    (dataDone),
        .dataRdata   (dataRdata),
        .fetchDone   (fetchDone),
        .fetchWord   (fetchWord),
        .owner       (owner)
    );

    byteRam #(
        .ramAddrBits(ramAddrBits)
    ) u_byteRam (
        .clk    (clk),
        .ramAddr(ramAddr),
        .ramWr  (ramWr),
        .rdByte (rdByte)
    );

endmodule

// ==== tests/memSubsystem_sva.sv ====
`timescale 1ns/1ps

module memCtrlChecks (
    input logic             clk,
    input logic             rst,
    input logic             ioBufferFull,
    input memPkg::accessLen stage,
    input cpuPkg::busOwner  owner,
    input logic             dataDone,
    input logic             fetchDone,
    input memPkg::ramWrite  ramWr
);
    int failCount = 0;

    // two busy cycles in a row belong to one transaction
    ownerHeld: assert property (
        @(posedge clk) disable iff (rst)
        (stage != '0) ##1 (stage != '0) |-> $stable(owner)
    ) else begin
        $error("owner changed in the middle of a transaction");
        failCount++;
    end

    doneExclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(dataDone && fetchDone)
    ) else begin
        $error("dataDone and fetchDone are high together");
        failCount++;
    end

    dataPulse: assert property (
        @(posedge clk) disable iff (rst)
        dataDone |=> !dataDone
    ) else begin
        $error("dataDone stayed high for more than one cycle");
        failCount++;
    end

    fetchPulse: assert property (
        @(posedge clk) disable iff (rst)
        fetchDone |=> !fetchDone
    ) else begin
        $error("fetchDone stayed high for more than one cycle");
        failCount++;
    end

    // no ram write while the io buffer is full
    noWriteFrozen: assert property (
        @(posedge clk) disable iff (rst)
        ioBufferFull |-> !ramWr.en
    ) else begin
        $error("ram write enabled while frozen");
        failCount++;
    end

endmodule

bind memCtrl memCtrlChecks protocolChecks (
    .clk         (clk),
    .rst         (rst),
    .ioBufferFull(ioBufferFull),
    .stage       (stage),
    .owner       (owner),
    .dataDone    (dataDone),
    .fetchDone   (fetchDone),
    .ramWr       (ramWr)
);

// ==== tests/memSubsystemTb.sv ====
`timescale 1ns/1ps

module memSubsystemTb;
    import memPkg::*;
    import cpuPkg::*;

    localparam int     ramAddrBits   = 12;
    localparam memAddr resetPc       = 32'h0;
    localparam int     ramBytes      = 1 << ramAddrBits;
    localparam int     timeoutCycles = 50;
    localparam memAddr regionBase    = 32'h100;

    logic    clk;
    logic    rst;
    logic    ioBufferFull;
    logic    dataEn;
    dataReq  dataRequest;
    logic    dataDone;
    memWord  dataRdata;
    logic    fetchEn;
    logic    redirect;
    memAddr  redirectPc;
    logic    instValid;
    fetchOut instOut;
    busOwner owner;

    integer seed = 32'h87fb;
    memByte refMem [ramBytes];
    memAddr expPc;

    memSubsystem #(
        .ramAddrBits(ramAddrBits),
        .resetPc    (resetPc)
    ) u_memSubsystem (
        .clk         (clk),
        .rst         (rst),
        .ioBufferFull(ioBufferFull),
        .dataEn      (dataEn),
        .dataRequest (dataRequest),
        .dataDone    (dataDone),
        .dataRdata   (dataRdata),
        .fetchEn     (fetchEn),
        .redirect    (redirect),
        .redirectPc  (redirectPc),
        .instValid   (instValid),
        .instOut     (instOut),
        .owner       (owner)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic reportFail(string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkEq(string name, memWord expected, memWord actual);
        assert (expected === actual)
        else reportFail($sformatf("Fail %s expected %h actual %h", name, expected, actual));
    endtask

    // protocol assertions bound into the controller
    always @(negedge clk) begin
        assert (u_memSubsystem.u_memCtrl.protocolChecks.failCount == 0)
        else reportFail("a protocol assertion in the memory controller failed");
    end

    function automatic int wrapAddr(memAddr addr);
        return int'(addr[ramAddrBits-1:0]);
    endfunction

    // little endian, zero extended
    function automatic memWord modelRead(memAddr addr, int len);
        memWord value;
        value = '0;
        for (int i = 0; i < len; i++) begin
            value[8*i +: 8] = refMem[wrapAddr(addr + memAddr'(i))];
        end
        return value;
    endfunction

    function automatic accessLen pickLen(int sel);
        case (sel)
            0:       return 3'd1;
            1:       return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

    task automatic waitData(output int cycles);
        cycles = 0;
        @(negedge clk);
        while (!dataDone) begin
            assert (!instValid)
            else reportFail("instValid pulsed while a data access was awaited");
            cycles++;
            assert (cycles < timeoutCycles)
            else reportFail($sformatf("dataDone never came within %0d cycles", timeoutCycles));
            @(negedge clk);
        end
    endtask

    task automatic waitInst();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!instValid) begin
            assert (!dataDone)
            else reportFail("dataDone pulsed while an instruction was awaited");
            cycles++;
            assert (cycles < timeoutCycles)
            else reportFail($sformatf("instValid never came within %0d cycles", timeoutCycles));
            @(negedge clk);
        end
    endtask

    task automatic startData(logic isStore, memAddr addr, accessLen len, memWord wdata);
        @(posedge clk);
        #1;
        dataEn = 1'b1;
        dataRequest = '{isStore: isStore, len: len, addr: addr, wdata: wdata};
    endtask

    task automatic endData();
        @(posedge clk);
        #1;
        dataEn = 1'b0;
    endtask

    task automatic storeData(memAddr addr, accessLen len, memWord wdata);
        int cycles;
        startData(1'b1, addr, len, wdata);
        waitData(cycles);
        checkEq("store latency", int'(len) - 1, cycles);
        for (int i = 0; i < int'(len); i++) begin
            refMem[wrapAddr(addr + memAddr'(i))] = wdata[8*i +: 8];
        end
        endData();
    endtask

    task automatic loadData(string name, memAddr addr, accessLen len, logic checkTiming);
        int cycles;
        startData(1'b0, addr, len, '0);
        waitData(cycles);
        checkEq(name, modelRead(addr, int'(len)), dataRdata);
        if (checkTiming) begin
            checkEq({name, " latency"}, int'(len) + 1, cycles);
        end
        endData();
    endtask

    task automatic startFetch();
        @(posedge clk);
        #1;
        fetchEn = 1'b1;
    endtask

    task automatic stopFetch();
        @(posedge clk);
        #1;
        fetchEn = 1'b0;
    endtask

    task automatic expectInst(string name);
        waitInst();
        checkEq({name, " pc"}, expPc, instOut.pc);
        checkEq({name, " inst"}, modelRead(expPc, 4), instOut.inst);
        expPc = expPc + 32'd4;
    endtask

    task automatic holdFreeze(int cycles);
        #1;
        ioBufferFull = 1'b1;
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            assert (!dataDone && !instValid)
            else reportFail("a done pulse appeared while the bus was frozen");
            @(posedge clk);
            #1;
        end
        ioBufferFull = 1'b0;
    endtask

    initial begin
        memAddr   addr;
        accessLen len;
        int       freezeCycles;

        rst = 1'b1;
        ioBufferFull = 1'b0;
        dataEn = 1'b0;
        dataRequest = '0;
        fetchEn = 1'b0;
        redirect = 1'b0;
        redirectPc = '0;
        expPc = resetPc;
        for (int i = 0; i < ramBytes; i++) begin
            refMem[i] = '0;
        end

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        // quiet after reset
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            assert (!dataDone && !instValid)
            else reportFail("a done pulse appeared with no request after reset");
            checkEq("reset owner", busIdle, owner);
        end

        for (int i = 0; i < 12; i++) begin
            addr = regionBase + memAddr'($unsigned($random(seed)) % 28);
            len = pickLen($unsigned($random(seed)) % 3);
            storeData(addr, len, $random(seed));
        end
        for (int i = 0; i < 12; i++) begin
            addr = regionBase + memAddr'($unsigned($random(seed)) % 28);
            len = pickLen($unsigned($random(seed)) % 3);
            loadData($sformatf("load %0d", i), addr, len, 1'b1);
        end

        // program words go in through the data port
        for (int i = 0; i < 16; i++) begin
            storeData(resetPc + memAddr'(4 * i), 3'd4, $random(seed));
        end
        startFetch();
        for (int i = 0; i < 8; i++) begin
            expectInst($sformatf("fetch %0d", i));
        end
        stopFetch();

        // data request arrives while a fetch is in flight
        startFetch();
        startData(1'b0, regionBase + 32'd4, 3'd4, '0);
        @(negedge clk);
        checkEq("arbitration owner", busFetch, owner);
        expectInst("arbitration fetch");
        stopFetch();
        begin
            int cycles;
            waitData(cycles);
            checkEq("arbitration load", modelRead(regionBase + 32'd4, 4), dataRdata);
            // word load sampled in the cycle after the fetch ends
            checkEq("arbitration load latency", 32'd5, cycles);
        end
        endData();

        addr = regionBase + memAddr'($unsigned($random(seed)) % 28);
        len = pickLen($unsigned($random(seed)) % 3);
        freezeCycles = 3 + ($unsigned($random(seed)) % 8);
        fork
            loadData("freeze load", addr, len, 1'b0);
            begin
                repeat (2) @(posedge clk);
                holdFreeze(freezeCycles);
            end
        join

        freezeCycles = 3 + ($unsigned($random(seed)) % 8);
        fork
            begin
                startFetch();
                expectInst("freeze fetch");
                stopFetch();
            end
            begin
                repeat (2) @(posedge clk);
                holdFreeze(freezeCycles);
            end
        join

        // stale word must be dropped
        startFetch();
        @(posedge clk);
        #1;
        redirect = 1'b1;
        redirectPc = resetPc + 32'd8;
        @(posedge clk);
        #1;
        redirect = 1'b0;
        expPc = resetPc + 32'd8;
        expectInst("redirect");
        stopFetch();

        repeat (3) @(negedge clk);
        if (u_memSubsystem.u_memCtrl.protocolChecks.failCount == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            reportFail("a protocol assertion in the memory controller failed");
        end
    end

endmodule

// ==== tb.f ====
rtl/memPkg.sv
rtl/cpuPkg.sv
rtl/byteRam.sv
rtl/memCtrl.sv
rtl/fetchUnit.sv
rtl/memSubsystem.sv
tests/memSubsystem_sva.sv
tests/memSubsystemTb.sv
